// File: blob_tracker.f
+incdir+tests
logic/blob_pkg.sv
logic/stream_reg.sv
logic/pixel_classifier.sv
logic/box_tracker.sv
logic/msg_writer.sv
logic/msg_fifo.sv
logic/mm_regs.sv
logic/blob_tracker.sv
tests/tb_blob_tracker.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_blob_tracker
FILELIST  ?= blob_tracker.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: tests/tb_blob_model.svh
// reference model of the blob tracker, hsv classes, output pixels and message words
`ifndef TB_BLOB_MODEL_SVH
`define TB_BLOB_MODEL_SVH

// class index 0 none, then red, green, blue, violet, yellow
function automatic int hsv_colour(blob_pkg::pixel_t p);
	int r, g, b, v, mn, d, h, s;
	r = p.red;
	g = p.green;
	b = p.blue;
	v = (r > g) ? r : g;
	v = (b > v) ? b : v;
	mn = (r < g) ? r : g;
	mn = (b < mn) ? b : mn;
	d = v - mn;
	s = (v == 0) ? 0 : (255 * d) / v;
	// hue in degrees first, int division truncates toward zero
	if (d == 0) begin
		h = 0;
	end else if (v == r) begin
		h = (60 * (g - b)) / d;
		if (g < b) h = h + 360;
	end else if (v == g) begin
		h = 120 + (60 * (b - r)) / d;
	end else begin
		h = 240 + (60 * (r - g)) / d;
	end
	h = h / 2;
	// first matching class wins
	if ((h > 170 || h < 25) && s > 149 && s < 232 && v > 125 && v <= 200) return 1;
	if (h > 60 && h < 80 && s > 75 && s < 200 && v > 50 && v <= 128) return 2;
	if (h > 90 && h < 120 && s > 76 && s < 195 && v > 25 && v <= 128) return 3;
	if (h < 15 && s > 80 && s < 150 && v > 75 && v <= 125) return 4;
	if (h > 25 && h < 45 && s > 100 && s < 153 && v > 102 && v <= 245) return 5;
	return 0;
endfunction

function automatic logic [23:0] highlight_of(int c);
	case (c)
		1: return 24'hff0001;
		2: return 24'h00ff00;
		3: return 24'h0000ff;
		4: return 24'h8e1596;
		5: return 24'hedff6f;
		default: return 24'h000000;
	endcase
endfunction

// outline colour, index 0 is red
function automatic logic [23:0] outline_of(int k);
	case (k)
		0: return 24'hff7575;
		1: return 24'h92ff96;
		2: return 24'h92eeff;
		3: return 24'hff92ea;
		default: return 24'hf9ff92;
	endcase
endfunction

function automatic bit on_border(int x, int y);
	return x <= BORDER || y <= BORDER || x >= IMG_W - BORDER || y >= IMG_H - BORDER;
endfunction

// outlines first in red-first order, then black border, then highlight
function automatic blob_pkg::pixel_t expected_pixel(blob_pkg::pixel_t p, int x, int y,
		blob_pkg::box_t [4:0] lat, logic [4:0] lat_seen);
	for (int k = 0; k < 5; k++) begin
		if (lat_seen[k] && (x == lat[k].xmin || x == lat[k].xmax
				|| y == lat[k].ymin || y == lat[k].ymax)) begin
			return outline_of(k);
		end
	end
	if (on_border(x, y)) return 24'h000000;
	return highlight_of(hsv_colour(p));
endfunction

// word idx 0..14, three per colour, unseen colours report zero corners
function automatic logic [31:0] message_word(int idx, blob_pkg::box_t [4:0] lat,
		logic [4:0] lat_seen);
	int k;
	k = idx / 3;
	if (idx % 3 == 0) begin
		case (k)
			0: return 32'h00524242;
			1: return 32'h00474242;
			2: return 32'h00424242;
			3: return 32'h00564242;
			default: return 32'h00594242;
		endcase
	end
	if (!lat_seen[k]) return 32'h0;
	if (idx % 3 == 1) return {5'd0, lat[k].xmin, 5'd0, lat[k].ymin};
	return {5'd0, lat[k].xmax, 5'd0, lat[k].ymax};
endfunction

`endif

// File: tests/tb_blob_tracker.sv
// testbench for the blob tracker covering stream pixels, outlines and the message port
`timescale 1ns/1ps

module tb_blob_tracker;

	localparam int IMG_W = 16;
	localparam int IMG_H = 12;
	localparam int BORDER = 1;
	localparam int INTERVAL = 2;
	localparam int TIMEOUT = 2000;
	localparam int NPIX = IMG_W * IMG_H;

	`include "tb_blob_model.svh"

	logic clk = 1'b0;
	logic reset_n;
	logic mode;
	blob_pkg::beat_t sink_data;
	logic sink_valid;
	logic sink_ready;
	blob_pkg::beat_t source_data;
	logic source_valid;
	logic source_ready = 1'b1;
	logic s_chipselect;
	logic s_read;
	logic s_write;
	blob_pkg::mm_addr_e s_address;
	logic [31:0] s_writedata;
	logic [31:0] s_readdata;

	// model state
	blob_pkg::beat_t exp_q [$];
	blob_pkg::beat_t got_q [$];
	logic [31:0] msg_q [$];
	blob_pkg::box_t [4:0] run_box;
	blob_pkg::box_t [4:0] lat_box;
	logic [4:0] run_seen = '0;
	logic [4:0] lat_seen = '0;
	int pos_x = 0;
	int pos_y = 0;
	bit in_video = 1'b0;
	int frame_cnt = 0;
	logic [7:0] status_byte = 8'h00;
	int in_count = 0;
	int out_count = 0;
	bit random_gaps = 1'b0;
	blob_pkg::pixel_t frame_pix [NPIX];

	blob_tracker #(
		.IMAGE_W(IMG_W), .IMAGE_H(IMG_H), .BORDER(BORDER),
		.MSG_INTERVAL(INTERVAL), .FIFO_DEPTH(256)
	) blob_tracker_inst (
		.clk(clk), .reset_n(reset_n), .mode(mode),
		.sink_data(sink_data), .sink_valid(sink_valid), .sink_ready(sink_ready),
		.source_data(source_data), .source_valid(source_valid), .source_ready(source_ready),
		.s_chipselect(s_chipselect), .s_read(s_read), .s_write(s_write),
		.s_address(s_address), .s_writedata(s_writedata), .s_readdata(s_readdata)
	);

	always #2 clk = ~clk;

	// random back-pressure on the source side
	always @(posedge clk) begin
		#1;
		source_ready = random_gaps ? ($urandom_range(3) != 0) : 1'b1;
	end

	////////////////////////////////////////////////////////////
	// source monitor and compare
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (reset_n && source_valid && source_ready) got_q.push_back(source_data);
	end

	always @(negedge clk) begin
		blob_pkg::beat_t got;
		while (got_q.size() > 0) begin
			got = got_q.pop_front();
			if (exp_q.size() == 0) begin
				report_failure("the DUT sent a beat that was never expected");
			end else begin
				check_beat("source_data", got, exp_q.pop_front());
				out_count++;
			end
		end
	end

	task automatic report_failure(string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_beat(string name, blob_pkg::beat_t got, blob_pkg::beat_t exp);
		if (got !== exp) begin
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
		end
	endtask

	////////////////////////////////////////////////////////////
	// model update per accepted sink beat
	////////////////////////////////////////////////////////////

	task automatic model_step(blob_pkg::beat_t b);
		blob_pkg::beat_t e;
		int c;
		int k;
		e = b;
		if (b.sop) begin
			pos_x = 0;
			pos_y = 0;
			in_video = (b.pix.blue[3:0] == 4'h0);
			run_seen = '0;
		end else begin
			c = hsv_colour(b.pix);
			// drawn from the boxes of the previous frame
			if (mode && in_video) e.pix = expected_pixel(b.pix, pos_x, pos_y, lat_box, lat_seen);
			if (c != 0 && !on_border(pos_x, pos_y)) begin
				k = c - 1;
				if (!run_seen[k] || pos_x < run_box[k].xmin) run_box[k].xmin = 11'(pos_x);
				if (!run_seen[k] || pos_x > run_box[k].xmax) run_box[k].xmax = 11'(pos_x);
				if (!run_seen[k] || pos_y < run_box[k].ymin) run_box[k].ymin = 11'(pos_y);
				run_box[k].ymax = 11'(pos_y);
				run_seen[k] = 1'b1;
			end
			if (b.eop && in_video) begin
				lat_box = run_box;
				lat_seen = run_seen;
				// messages every INTERVAL frames starting with the first
				if (frame_cnt == 0) begin
					frame_cnt = INTERVAL - 1;
					for (int i = 0; i < 15; i++) msg_q.push_back(message_word(i, lat_box, lat_seen));
				end else begin
					frame_cnt--;
				end
			end
			if (pos_x == IMG_W - 1) begin
				pos_x = 0;
				pos_y++;
			end else begin
				pos_x++;
			end
		end
		exp_q.push_back(e);
		in_count++;
	endtask

	////////////////////////////////////////////////////////////
	// stream stimulus
	////////////////////////////////////////////////////////////

	task automatic send_beat(blob_pkg::beat_t b);
		int n;
		if (random_gaps && $urandom_range(3) == 0) begin
			sink_valid = 1'b0;
			@(posedge clk);
			#1;
		end
		sink_data = b;
		sink_valid = 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
			if (n > TIMEOUT) report_failure("timeout, the sink never accepted a beat");
		end while (!sink_ready);
		model_step(b);
		#1;
		sink_valid = 1'b0;
	endtask

	// blue low nibble nonzero marks a non-video packet
	task automatic send_other_packet(int len);
		blob_pkg::beat_t b;
		b.pix = 24'($urandom() & 32'hfffff0) | 24'($urandom_range(1, 15));
		b.sop = 1'b1;
		b.eop = 1'b0;
		send_beat(b);
		for (int i = 0; i < len; i++) begin
			b.pix = 24'($urandom());
			b.sop = 1'b0;
			b.eop = (i == len - 1);
			send_beat(b);
		end
	endtask

	// one pixel inside each colour rule in red-first order
	function automatic logic [23:0] patch_pixel(int c);
		case (c)
			1: return 24'hb4281e;
			2: return 24'h1e783c;
			3: return 24'h285a6e;
			4: return 24'h6e3c32;
			default: return 24'hc8c864;
		endcase
	endfunction

	task automatic send_frame();
		blob_pkg::beat_t b;
		int x0, y0, w, h;
		for (int i = 0; i < NPIX; i++) frame_pix[i] = 24'($urandom());
		// patches may spill into the border and over each other
		for (int c = 1; c <= 5; c++) begin
			x0 = $urandom_range(0, IMG_W - 3);
			y0 = $urandom_range(0, IMG_H - 3);
			w = $urandom_range(2, 4);
			h = $urandom_range(2, 3);
			for (int y = y0; y < y0 + h && y < IMG_H; y++) begin
				for (int x = x0; x < x0 + w && x < IMG_W; x++) begin
					frame_pix[y * IMG_W + x] = patch_pixel(c);
				end
			end
		end
		b.pix = 24'($urandom() & 32'hfffff0);
		b.sop = 1'b1;
		b.eop = 1'b0;
		send_beat(b);
		for (int i = 0; i < NPIX; i++) begin
			b.pix = frame_pix[i];
			b.sop = 1'b0;
			b.eop = (i == NPIX - 1);
			send_beat(b);
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (out_count != in_count) begin
			@(posedge clk);
			#1;
			n++;
			if (n > TIMEOUT) report_failure("timeout, beats are still missing at the source");
		end
	endtask

	////////////////////////////////////////////////////////////
	// register port
	////////////////////////////////////////////////////////////

	task automatic bus_read(blob_pkg::mm_addr_e addr, output logic [31:0] data);
		s_chipselect = 1'b1;
		s_read = 1'b1;
		s_address = addr;
		@(posedge clk);
		#1;
		s_chipselect = 1'b0;
		s_read = 1'b0;
		// registered one cycle after the read
		@(posedge clk);
		data = s_readdata;
		#1;
	endtask

	task automatic bus_write(blob_pkg::mm_addr_e addr, logic [31:0] data);
		s_chipselect = 1'b1;
		s_write = 1'b1;
		s_address = addr;
		s_writedata = data;
		@(posedge clk);
		#1;
		s_chipselect = 1'b0;
		s_write = 1'b0;
	endtask

	task automatic wait_level(int want);
		logic [31:0] st;
		int n;
		n = 0;
		bus_read(blob_pkg::ADDR_STATUS, st);
		while (int'(st[15:8]) != want) begin
			n++;
			if (n > 100) report_failure("timeout, the message FIFO never reached its level");
			bus_read(blob_pkg::ADDR_STATUS, st);
		end
	endtask

	task automatic check_status();
		logic [31:0] st;
		bus_read(blob_pkg::ADDR_STATUS, st);
		check_word("s_readdata status", st,
			{16'h0, 8'(msg_q.size()), status_byte[7:5], 1'b0, status_byte[3:0]});
	endtask

	task automatic read_messages(int n);
		logic [31:0] w;
		for (int i = 0; i < n; i++) begin
			bus_read(blob_pkg::ADDR_MSG, w);
			check_word("s_readdata msg", w, msg_q.pop_front());
		end
	endtask

	initial begin
		logic [31:0] w;
		reset_n = 1'b0;
		mode = 1'b0;
		sink_data = '0;
		sink_valid = 1'b0;
		s_chipselect = 1'b0;
		s_read = 1'b0;
		s_write = 1'b0;
		s_address = blob_pkg::ADDR_STATUS;
		s_writedata = '0;
		void'($urandom(87529));
		repeat (10) @(posedge clk);
		#1;
		reset_n = 1'b1;

		// pass-through with mode low
		random_gaps = 1'b1;
		repeat (3) send_other_packet($urandom_range(5, 20));
		wait_drained();

		// first video frame has nothing seen yet so no outlines
		mode = 1'b1;
		send_frame();
		wait_drained();
		wait_level(msg_q.size());
		check_status();
		read_messages(15);
		check_status();
		bus_read(blob_pkg::ADDR_ID, w);
		check_word("s_readdata id", w, 32'h1234eee2);

		// non-video packet untouched in mode high
		send_other_packet(12);
		wait_drained();

		// second frame carries outlines and writes no messages
		send_frame();
		wait_drained();
		// the writer finishes within 17 cycles of the eop transfer
		repeat (20) @(posedge clk);
		#1;
		check_status();

		// third frame writes again and a flush follows
		send_frame();
		wait_drained();
		wait_level(msg_q.size());
		check_status();
		read_messages(3);
		bus_write(blob_pkg::ADDR_STATUS, 32'h13);
		status_byte = 8'h13;
		msg_q.delete();
		check_status();

		// a video frame with mode low leaves every pixel as it came
		mode = 1'b0;
		send_frame();
		wait_drained();

		if (exp_q.size() != 0 || got_q.size() != 0 || msg_q.size() != 0) begin
			report_failure("beats or messages were left unchecked at the end");
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

// File: logic/blob_tracker.sv
// colour blob tracker top level, stream pipeline plus message port
`timescale 1ns/1ps

module blob_tracker #(
	parameter int IMAGE_W      = 640,
	parameter int IMAGE_H      = 480,
	parameter int BORDER       = 20,
	parameter int MSG_INTERVAL = 6,
	parameter int FIFO_DEPTH   = 256
) (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               mode,
	input  blob_pkg::beat_t    sink_data,
	input  logic               sink_valid,
	output logic               sink_ready,
	output blob_pkg::beat_t    source_data,
	output logic               source_valid,
	input  logic               source_ready,
	input  logic               s_chipselect,
	input  logic               s_read,
	input  logic               s_write,
	input  blob_pkg::mm_addr_e s_address,
	input  logic [31:0]        s_writedata,
	output logic [31:0]        s_readdata
);

	blob_pkg::beat_t in_beat, out_beat;
	logic in_valid, out_ready;
	blob_pkg::colour_e colour;
	blob_pkg::box_t [blob_pkg::NUM_COLOURS-1:0] boxes;
	logic [blob_pkg::NUM_COLOURS-1:0] seen;
	logic frame_done;
	logic [31:0] msg_word, fifo_q;
	logic msg_write;
	logic [7:0] fifo_level;
	logic fifo_empty, fifo_pop, fifo_clear;

	////////////////////////////////////////////////////////////
	// video path
	////////////////////////////////////////////////////////////

	stream_reg in_reg (
		.clk(clk), .reset_n(reset_n),
		.data_in(sink_data), .valid_in(sink_valid), .ready_out(sink_ready),
		.data_out(in_beat), .valid_out(in_valid), .ready_in(out_ready)
	);

	pixel_classifier pixel_classifier_inst (
		.pixel(in_beat.pix), .colour(colour)
	);

	box_tracker #(.IMAGE_W(IMAGE_W), .IMAGE_H(IMAGE_H), .BORDER(BORDER)) box_tracker_inst (
		.clk(clk), .reset_n(reset_n), .mode(mode),
		.in_beat(in_beat), .in_valid(in_valid), .out_ready(out_ready),
		.colour(colour), .out_beat(out_beat),
		.boxes(boxes), .seen(seen), .frame_done(frame_done)
	);

	stream_reg out_reg (
		.clk(clk), .reset_n(reset_n),
		.data_in(out_beat), .valid_in(in_valid), .ready_out(out_ready),
		.data_out(source_data), .valid_out(source_valid), .ready_in(source_ready)
	);

	////////////////////////////////////////////////////////////
	// message path
	////////////////////////////////////////////////////////////

	msg_writer #(.MSG_INTERVAL(MSG_INTERVAL), .FIFO_DEPTH(FIFO_DEPTH)) msg_writer_inst (
		.clk(clk), .reset_n(reset_n), .frame_done(frame_done),
		.boxes(boxes), .seen(seen), .fifo_level(fifo_level),
		.msg_word(msg_word), .msg_write(msg_write)
	);

	msg_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) msg_fifo_inst (
		.clk(clk), .reset_n(reset_n),
		.wr_data(msg_word), .write(msg_write),
		.pop(fifo_pop), .clear(fifo_clear),
		.q(fifo_q), .level(fifo_level), .empty(fifo_empty)
	);

	mm_regs mm_regs_inst (
		.clk(clk), .reset_n(reset_n),
		.s_chipselect(s_chipselect), .s_read(s_read), .s_write(s_write),
		.s_address(s_address), .s_writedata(s_writedata), .s_readdata(s_readdata),
		.fifo_q(fifo_q), .fifo_level(fifo_level), .fifo_empty(fifo_empty),
		.fifo_pop(fifo_pop), .fifo_clear(fifo_clear)
	);

endmodule

// File: logic/mm_regs.sv
// memory-mapped port for status, message reads, chip id and fifo flush
`timescale 1ns/1ps

module mm_regs (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               s_chipselect,
	input  logic               s_read,
	input  logic               s_write,
	input  blob_pkg::mm_addr_e s_address,
	input  logic [31:0]        s_writedata,
	output logic [31:0]        s_readdata,
	input  logic [31:0]        fifo_q,
	input  logic [7:0]         fifo_level,
	input  logic               fifo_empty,
	output logic               fifo_pop,
	output logic               fifo_clear
);

	logic [7:0] status_reg;
	logic read_d;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			status_reg <= 8'h00;
		end else if (s_chipselect && s_write && s_address == blob_pkg::ADDR_STATUS) begin
			status_reg <= s_writedata[7:0];
		end
	end

	// bit 4 of a status write flushes the fifo
	assign fifo_clear = s_chipselect && s_write && s_address == blob_pkg::ADDR_STATUS
		&& s_writedata[4];

	// pop once per read pulse, on its first cycle
	assign fifo_pop = s_chipselect && s_read && !read_d && !fifo_empty
		&& s_address == blob_pkg::ADDR_MSG;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			s_readdata <= '0;
			read_d <= 1'b0;
		end else begin
			read_d <= s_read;
			if (s_chipselect && s_read) begin
				case (s_address)
					// flush bit is write-only
					blob_pkg::ADDR_STATUS: s_readdata <= {16'h0, fifo_level, status_reg & 8'hef};
					blob_pkg::ADDR_MSG: s_readdata <= fifo_q;
					blob_pkg::ADDR_ID: s_readdata <= blob_pkg::CHIP_ID;
					default: s_readdata <= '0;
				endcase
			end
		end
	end

endmodule

// File: logic/msg_fifo.sv
// show-ahead circular message fifo with level, empty and clear
`timescale 1ns/1ps

module msg_fifo #(
	parameter int FIFO_DEPTH = 256
) (
	input  logic        clk,
	input  logic        reset_n,
	input  logic [31:0] wr_data,
	input  logic        write,
	input  logic        pop,
	input  logic        clear,
	output logic [31:0] q,
	output logic [7:0]  level,
	output logic        empty
);

	localparam int AW = $clog2(FIFO_DEPTH);

	logic [31:0] mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr, rd_ptr;
	logic [AW-1:0] count;

	// one slot stays unused, so equal pointers always mean empty
	assign count = wr_ptr - rd_ptr;
	assign level = 8'(count);
	assign empty = (wr_ptr == rd_ptr);
	assign q = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (!reset_n || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (write && count != AW'(FIFO_DEPTH - 1)) wr_ptr <= wr_ptr + 1'b1;
			if (pop && !empty) rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (write) mem[wr_ptr] <= wr_data;
	end

endmodule

// File: logic/msg_writer.sv
// counts frames and writes the fifteen box message words every interval
`timescale 1ns/1ps

module msg_writer #(
	parameter int MSG_INTERVAL = 6,
	parameter int FIFO_DEPTH   = 256
) (
	input  logic                                      clk,
	input  logic                                      reset_n,
	input  logic                                      frame_done,
	input  blob_pkg::box_t [blob_pkg::NUM_COLOURS-1:0] boxes,
	input  logic [blob_pkg::NUM_COLOURS-1:0]          seen,
	input  logic [7:0]                                fifo_level,
	output logic [31:0]                               msg_word,
	output logic                                      msg_write
);

	blob_pkg::msg_state_e state;
	logic [7:0] frame_cnt;
	logic [3:0] step;
	logic [2:0] sel;
	logic room;

	// fifteen free places still leave the fifo one short of full
	assign room = int'(fifo_level) + 15 < FIFO_DEPTH;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			frame_cnt <= '0;
			state <= blob_pkg::MSG_IDLE;
		end else begin
			// last word state rolls over into idle
			if (state != blob_pkg::MSG_IDLE) begin
				state <= blob_pkg::msg_state_e'(state + 4'd1);
			end
			if (frame_done) begin
				if (frame_cnt == 8'd0) begin
					frame_cnt <= 8'(MSG_INTERVAL - 1);
					if (room && state == blob_pkg::MSG_IDLE) begin
						state <= blob_pkg::MSG_R_ID;
					end
				end else begin
					frame_cnt <= frame_cnt - 8'd1;
				end
			end
		end
	end

	// colour index and word within the group of three
	assign step = state - 4'd1;
	assign sel = 3'(step / 4'd3);
	assign msg_write = (state != blob_pkg::MSG_IDLE);

	always_comb begin
		msg_word = '0;
		if (msg_write) begin
			case (step % 4'd3)
				4'd0: msg_word = blob_pkg::MSG_ID[sel];
				4'd1: msg_word = {16'(boxes[sel].xmin), 16'(boxes[sel].ymin)};
				default: msg_word = {16'(boxes[sel].xmax), 16'(boxes[sel].ymax)};
			endcase
			// a colour not seen last frame reports zero corners
			if (step % 4'd3 != 4'd0 && !seen[sel]) begin
				msg_word = '0;
			end
		end
	end

endmodule

// File: logic/box_tracker.sv
// frame coordinates, per-colour bounding boxes and output pixel selection
`timescale 1ns/1ps

module box_tracker #(
	parameter int IMAGE_W = 640,
	parameter int IMAGE_H = 480,
	parameter int BORDER  = 20
) (
	input  logic                                      clk,
	input  logic                                      reset_n,
	input  logic                                      mode,
	input  blob_pkg::beat_t                           in_beat,
	input  logic                                      in_valid,
	input  logic                                      out_ready,
	input  blob_pkg::colour_e                         colour,
	output blob_pkg::beat_t                           out_beat,
	output blob_pkg::box_t [blob_pkg::NUM_COLOURS-1:0] boxes,
	output logic [blob_pkg::NUM_COLOURS-1:0]          seen,
	output logic                                      frame_done
);

	localparam blob_pkg::coord_t X_LAST = blob_pkg::coord_t'(IMAGE_W - 1);
	localparam blob_pkg::coord_t Y_LAST = blob_pkg::coord_t'(IMAGE_H - 1);

	blob_pkg::coord_t x, y;
	logic is_video;
	logic xfer;
	logic border;
	logic frame_end;
	blob_pkg::box_t [blob_pkg::NUM_COLOURS-1:0] run_box;
	logic [blob_pkg::NUM_COLOURS-1:0] run_seen;

	// only a beat moving into out_reg counts
	assign xfer = in_valid && out_ready;
	assign frame_end = xfer && in_beat.eop && !in_beat.sop && is_video;

	assign border = (x <= BORDER) || (y <= BORDER) || (x >= IMAGE_W - BORDER)
		|| (y >= IMAGE_H - BORDER);

	////////////////////////////////////////////////////////////
	// pixel position and packet type
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x <= '0;
			y <= '0;
			is_video <= 1'b0;
		end else if (xfer) begin
			if (in_beat.sop) begin
				x <= '0;
				y <= '0;
				// video packets carry zero in the low nibble of blue
				is_video <= (in_beat.pix.blue[3:0] == 4'h0);
			end else if (x == X_LAST) begin
				x <= '0;
				y <= y + 1'b1;
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// running boxes for the current frame
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			run_seen <= '0;
		end else if (xfer) begin
			if (in_beat.sop) begin
				// start inverted so the first hit sets every edge
				run_seen <= '0;
				for (int c = 0; c < blob_pkg::NUM_COLOURS; c++) begin
					run_box[c] <= '{xmin: X_LAST, ymin: Y_LAST, xmax: '0, ymax: '0};
				end
			end else if (!border) begin
				for (int c = 0; c < blob_pkg::NUM_COLOURS; c++) begin
					if (int'(colour) == c + 1) begin
						if (x < run_box[c].xmin) run_box[c].xmin <= x;
						if (x > run_box[c].xmax) run_box[c].xmax <= x;
						if (y < run_box[c].ymin) run_box[c].ymin <= y;
						// rows arrive in order, so the latest row is the bottom
						run_box[c].ymax <= y;
						run_seen[c] <= 1'b1;
					end
				end
			end
		end
	end

	// end of a video frame, hold boxes for the next frame's overlay
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			seen <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= frame_end;
			if (frame_end) begin
				boxes <= run_box;
				seen <= run_seen;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// output pixel
	////////////////////////////////////////////////////////////

	always_comb begin
		out_beat = in_beat;
		// sop words and non-video packets are left alone
		if (mode && !in_beat.sop && is_video) begin
			out_beat.pix = border ? blob_pkg::HIGHLIGHT[blob_pkg::COL_NONE]
				: blob_pkg::HIGHLIGHT[colour];
			// outline lines across the frame, red drawn on top
			for (int c = blob_pkg::NUM_COLOURS - 1; c >= 0; c--) begin
				if (seen[c] && (x == boxes[c].xmin || x == boxes[c].xmax
						|| y == boxes[c].ymin || y == boxes[c].ymax)) begin
					out_beat.pix = blob_pkg::BOX_COLOUR[c];
				end
			end
		end
	end

endmodule

// File: logic/pixel_classifier.sv
// converts one rgb pixel to hsv and picks the matching colour class
`timescale 1ns/1ps

module pixel_classifier (
	input  blob_pkg::pixel_t  pixel,
	output blob_pkg::colour_e colour
);

	logic [7:0] r, g, b;
	logic [7:0] v_max, v_min, delta;
	logic [7:0] h, s;

	assign r = pixel.red;
	assign g = pixel.green;
	assign b = pixel.blue;

	////////////////////////////////////////////////////////////
	// value, saturation
	////////////////////////////////////////////////////////////

	// value is the largest channel
	assign v_max = (r >= g && r >= b) ? r : (g >= b) ? g : b;
	assign v_min = (r <= g && r <= b) ? r : (g <= b) ? g : b;
	assign delta = v_max - v_min;

	// scaled to 0..255, black has no saturation
	assign s = (v_max == 8'd0) ? 8'd0 : 8'((16'd255 * delta) / v_max);

	////////////////////////////////////////////////////////////
	// hue in degrees, then halved to fit 8 bits
	////////////////////////////////////////////////////////////

	always_comb begin
		int hue;
		hue = 0;
		// signed divide truncates toward zero
		if (delta == 8'd0) begin
			hue = 0;
		end else if (r >= g && r >= b) begin
			hue = (60 * (int'(g) - int'(b))) / int'(delta);
			if (g < b) begin
				hue = hue + 360;
			end
		end else if (g >= b) begin
			hue = 120 + (60 * (int'(b) - int'(r))) / int'(delta);
		end else begin
			hue = 240 + (60 * (int'(r) - int'(g))) / int'(delta);
		end
		// below 360 before halving, so 8 bits hold it
		h = 8'(hue / 2);
	end

	////////////////////////////////////////////////////////////
	// rule match
	////////////////////////////////////////////////////////////

	always_comb begin
		blob_pkg::hsv_rule_t rule;
		logic h_ok;
		colour = blob_pkg::COL_NONE;
		// walk backwards so the lowest matching colour is left standing
		for (int c = blob_pkg::NUM_COLOURS - 1; c >= 0; c--) begin
			rule = blob_pkg::COLOUR_RULES[c];
			if (rule.h_wrap[0]) begin
				h_ok = (h > rule.h_hi) || (h < rule.h_lo);
			end else begin
				h_ok = (h > rule.h_lo) && (h < rule.h_hi);
			end
			if (h_ok && s > rule.s_lo && s < rule.s_hi && v_max > rule.v_lo
					&& v_max <= rule.v_hi) begin
				colour = blob_pkg::colour_e'(3'(c + 1));
			end
		end
	end

endmodule

// File: logic/stream_reg.sv
// one valid/ready register stage holding a single stream beat
`timescale 1ns/1ps

module stream_reg (
	input  logic            clk,
	input  logic            reset_n,
	input  blob_pkg::beat_t data_in,
	input  logic            valid_in,
	output logic            ready_out,
	output blob_pkg::beat_t data_out,
	output logic            valid_out,
	input  logic            ready_in
);

	// accept when empty or when the held beat leaves this cycle
	assign ready_out = !valid_out || ready_in;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_out <= 1'b0;
		end else if (ready_out) begin
			valid_out <= valid_in;
		end
	end

	// payload only loads on a real transfer
	always_ff @(posedge clk) begin
		if (ready_out && valid_in) begin
			data_out <= data_in;
		end
	end

endmodule

// File: logic/blob_pkg.sv
// shared types, colour rules, message ids and register map of the blob tracker
package blob_pkg;

	////////////////////////////////////////////////////////////
	// stream types
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} pixel_t;

	// one stream word, pixel plus packet marks
	typedef struct packed {
		pixel_t pix;
		logic   sop;
		logic   eop;
	} beat_t;

	typedef logic [10:0] coord_t;

	typedef struct packed {
		coord_t xmin;
		coord_t ymin;
		coord_t xmax;
		coord_t ymax;
	} box_t;

	// enum order is also detection priority
	typedef enum logic [2:0] {
		COL_NONE,
		COL_RED,
		COL_GREEN,
		COL_BLUE,
		COL_VIOLET,
		COL_YELLOW
	} colour_e;

	localparam int NUM_COLOURS = 5;

	////////////////////////////////////////////////////////////
	// colour rules, all bounds exclusive except v_hi
	////////////////////////////////////////////////////////////

	// with h_wrap set the hue matches above h_hi or below h_lo
	typedef struct packed {
		logic [7:0] h_lo;
		logic [7:0] h_hi;
		logic [7:0] h_wrap;
		logic [7:0] s_lo;
		logic [7:0] s_hi;
		logic [7:0] v_lo;
		logic [7:0] v_hi;
	} hsv_rule_t;

	// index 0 is red, through 4 for yellow
	localparam hsv_rule_t COLOUR_RULES [NUM_COLOURS] = '{
		'{8'd25, 8'd170, 8'd1, 8'd149, 8'd232, 8'd125, 8'd200},
		'{8'd60, 8'd80, 8'd0, 8'd75, 8'd200, 8'd50, 8'd128},
		'{8'd90, 8'd120, 8'd0, 8'd76, 8'd195, 8'd25, 8'd128},
		// violet is hue below 15 only, the high side can never match
		'{8'd15, 8'd255, 8'd1, 8'd80, 8'd150, 8'd75, 8'd125},
		'{8'd25, 8'd45, 8'd0, 8'd100, 8'd153, 8'd102, 8'd245}
	};

	// indexed by colour_e, none paints black
	localparam pixel_t HIGHLIGHT [6] = '{
		24'h000000, 24'hff0001, 24'h00ff00, 24'h0000ff, 24'h8e1596, 24'hedff6f
	};

	// outline pixel, index 0 is red
	localparam pixel_t BOX_COLOUR [NUM_COLOURS] = '{
		24'hff7575, 24'h92ff96, 24'h92eeff, 24'hff92ea, 24'hf9ff92
	};

	////////////////////////////////////////////////////////////
	// messages and register map
	////////////////////////////////////////////////////////////

	localparam logic [31:0] MSG_ID [NUM_COLOURS] = '{
		{8'h00, "RBB"}, {8'h00, "GBB"}, {8'h00, "BBB"}, {8'h00, "VBB"}, {8'h00, "YBB"}
	};

	localparam logic [31:0] CHIP_ID = 32'h1234eee2;

	typedef enum logic [2:0] {
		ADDR_STATUS = 3'd0,
		ADDR_MSG    = 3'd1,
		ADDR_ID     = 3'd2
	} mm_addr_e;

	// three words per colour, id then top-left then bottom-right
	typedef enum logic [3:0] {
		MSG_IDLE,
		MSG_R_ID, MSG_R_TL, MSG_R_BR,
		MSG_G_ID, MSG_G_TL, MSG_G_BR,
		MSG_B_ID, MSG_B_TL, MSG_B_BR,
		MSG_V_ID, MSG_V_TL, MSG_V_BR,
		MSG_Y_ID, MSG_Y_TL, MSG_Y_BR
	} msg_state_e;

endpackage
